/* include/masked_bv4_inv_config.svh */
`ifndef MASKED_BV4_INV_CONFIG_SVH
`define MASKED_BV4_INV_CONFIG_SVH

// number of boolean shares per value.
`define NUM_SHARES 2

// register stages from request to response.
`define INV_LATENCY 2

// r and p words per share pair, one multiplier in the theta stage.
`define RND_THETA_BITS (2 * `NUM_SHARES * (`NUM_SHARES - 1))
`define RND_INV_BITS (2 * `RND_THETA_BITS)
`define RND_BITS (`RND_THETA_BITS + `RND_INV_BITS)

`endif

/* src/aes128_package.sv */
`include "masked_bv4_inv_config.svh"

package aes128_package;

    // gf(2^2) element in normal basis {w^2, w}, bit 1 is the w coefficient.
    typedef logic [1:0] bv2_t;

    // gf(2^4) element, gamma1 in the upper pair.
    typedef logic [3:0] bv4_t;

    typedef bv2_t [`NUM_SHARES-1:0] bv2_shares_t;
    typedef bv4_t [`NUM_SHARES-1:0] bv4_shares_t;

    typedef struct packed {
        bv4_shares_t data;
        logic [`RND_BITS-1:0] random;
    } inv_req_t;

    typedef struct packed {
        bv4_shares_t data;
    } inv_rsp_t;

    function automatic int num_quad(input int n);
        return (n * (n - 1)) / 2;
    endfunction

    // squaring swaps the coefficients, same as inversion.
    function automatic bv2_t bv2_sq(input bv2_t a);
        return {a[0], a[1]};
    endfunction

    // multiply by sigma = w^2.
    function automatic bv2_t bv2_scl_sigma(input bv2_t a);
        return {a[1] ^ a[0], a[1]};
    endfunction

    function automatic bv2_t bv2_mul(input bv2_t a, input bv2_t b);
        logic e;
        e = (a[1] ^ a[0]) & (b[1] ^ b[0]);
        return {(a[1] & b[1]) ^ e, (a[0] & b[0]) ^ e};
    endfunction

endpackage

/* src/masked_hpc3_mul.sv */
`timescale 1ns/10ps
`include "masked_bv4_inv_config.svh"

module masked_hpc3_mul #(
    parameter int NUM_SHARES = `NUM_SHARES,
    parameter int BIT_WIDTH = 2,
    localparam int NUM_QUAD = aes128_package::num_quad(NUM_SHARES)
) (
    input  bit                                    clock,
    input  bit                                    reset,
    input  bit                                    enable,
    input  aes128_package::bv2_t [NUM_SHARES-1:0] a,
    input  aes128_package::bv2_t [NUM_SHARES-1:0] b,
    input  aes128_package::bv2_t [NUM_QUAD-1:0]   r,
    input  aes128_package::bv2_t [NUM_QUAD-1:0]   p,
    output aes128_package::bv2_t [NUM_SHARES-1:0] c
);

    // the diagonal of u carries the own-share product.
    logic [NUM_SHARES-1:0][NUM_SHARES-1:0][BIT_WIDTH-1:0] u_d;
    logic [NUM_SHARES-1:0][NUM_SHARES-1:0][BIT_WIDTH-1:0] u_q;
    logic [NUM_SHARES-1:0][NUM_SHARES-1:0][BIT_WIDTH-1:0] v_d;
    logic [NUM_SHARES-1:0][NUM_SHARES-1:0][BIT_WIDTH-1:0] v_q;

    for (genvar i = 0; i < NUM_SHARES; i++) begin : g_row
        for (genvar j = 0; j < NUM_SHARES; j++) begin : g_col
            if (i == j) begin : g_own
                assign u_d[i][j] = aes128_package::bv2_mul(a[i], b[i]);
                assign v_d[i][j] = '0;
            end else begin : g_cross
                localparam int LO = (i < j) ? i : j;
                localparam int HI = (i < j) ? j : i;
                // pair index, shared by (i, j) and (j, i).
                localparam int Q = LO * NUM_SHARES - (LO * (LO + 1)) / 2 + HI - LO - 1;

                assign u_d[i][j] = aes128_package::bv2_mul(a[i], b[j] ^ r[Q]) ^ p[Q];
                // ~a is a + 1 in this basis, so u ^ v leaves a*b plus r.
                assign v_d[i][j] = aes128_package::bv2_mul(~a[i], r[Q]) ^ p[Q];
            end
        end
    end

    // hold the terms while in reset.
    always_ff @(posedge clock) begin
        if (enable && !reset) begin
            u_q <= u_d;
            v_q <= v_d;
        end
    end

    // r terms cancel pairwise across shares.
    always_comb begin
        for (int i = 0; i < NUM_SHARES; i++) begin
            c[i] = '0;
            for (int j = 0; j < NUM_SHARES; j++) begin
                c[i] = c[i] ^ u_q[i][j] ^ v_q[i][j];
            end
        end
    end

endmodule

/* src/masked_bv4_comp_theta.sv */
`timescale 1ns/10ps
`include "masked_bv4_inv_config.svh"

// theta = (gamma1*gamma0 + (gamma1 + gamma0)^2 * sigma)^-1 on shares.
module masked_bv4_comp_theta #(
    parameter int NUM_SHARES = `NUM_SHARES
) (
    input  bit                                    clock,
    input  bit                                    reset,
    input  bit                                    enable,
    input  aes128_package::bv4_t [NUM_SHARES-1:0] a,
    input  logic [`RND_THETA_BITS-1:0]            random,
    output aes128_package::bv2_t [NUM_SHARES-1:0] b
);

    localparam int NUM_QUAD = aes128_package::num_quad(NUM_SHARES);

    aes128_package::bv2_t [NUM_QUAD-1:0]   random_r;
    aes128_package::bv2_t [NUM_QUAD-1:0]   random_p;
    aes128_package::bv2_t [NUM_SHARES-1:0] gamma1;
    aes128_package::bv2_t [NUM_SHARES-1:0] gamma0;
    aes128_package::bv2_t [NUM_SHARES-1:0] gamma1_q;
    aes128_package::bv2_t [NUM_SHARES-1:0] gamma0_q;
    aes128_package::bv2_t [NUM_SHARES-1:0] product;
    aes128_package::bv2_t [NUM_SHARES-1:0] norm;

    assign {random_r, random_p} = random;

    always_comb begin
        for (int i = 0; i < NUM_SHARES; i++) begin
            gamma1[i] = a[i][3:2];
            gamma0[i] = a[i][1:0];
        end
    end

    masked_hpc3_mul #(
        .NUM_SHARES(NUM_SHARES),
        .BIT_WIDTH (2)
    ) u_mul (
        .clock (clock),
        .reset (reset),
        .enable(enable),
        .a     (gamma1),
        .b     (gamma0),
        .r     (random_r),
        .p     (random_p),
        .c     (product)
    );

    // halves kept level with the multiplier register.
    always_ff @(posedge clock) begin
        if (enable && !reset) begin
            gamma1_q <= gamma1;
            gamma0_q <= gamma0;
        end
    end

    // square and scale are linear, so share by share.
    always_comb begin
        for (int i = 0; i < NUM_SHARES; i++) begin
            norm[i] = product[i] ^ aes128_package::bv2_scl_sigma(
                aes128_package::bv2_sq(gamma1_q[i] ^ gamma0_q[i]));
            b[i] = aes128_package::bv2_sq(norm[i]);
        end
    end

endmodule

/* src/masked_bv4_inv.sv */
`timescale 1ns/10ps
`include "masked_bv4_inv_config.svh"

module masked_bv4_inv #(
    parameter int NUM_SHARES = `NUM_SHARES
) (
    input  bit                                    clock,
    input  bit                                    reset,
    input  bit                                    enable,
    input  aes128_package::bv4_t [NUM_SHARES-1:0] a,
    input  logic [`RND_THETA_BITS-1:0]            random_theta,
    input  logic [`RND_INV_BITS-1:0]              random_inv,
    output aes128_package::bv4_t [NUM_SHARES-1:0] b
);

    localparam int NUM_QUAD = aes128_package::num_quad(NUM_SHARES);

    aes128_package::bv2_t [NUM_QUAD-1:0]   random_r_hi;
    aes128_package::bv2_t [NUM_QUAD-1:0]   random_p_hi;
    aes128_package::bv2_t [NUM_QUAD-1:0]   random_r_lo;
    aes128_package::bv2_t [NUM_QUAD-1:0]   random_p_lo;
    aes128_package::bv4_t [NUM_SHARES-1:0] a_q;
    aes128_package::bv2_t [NUM_SHARES-1:0] gamma1_q;
    aes128_package::bv2_t [NUM_SHARES-1:0] gamma0_q;
    aes128_package::bv2_t [NUM_SHARES-1:0] theta;
    aes128_package::bv2_t [NUM_SHARES-1:0] half_hi;
    aes128_package::bv2_t [NUM_SHARES-1:0] half_lo;

    assign {random_r_hi, random_p_hi, random_r_lo, random_p_lo} = random_inv;

    masked_bv4_comp_theta #(
        .NUM_SHARES(NUM_SHARES)
    ) u_comp_theta (
        .clock (clock),
        .reset (reset),
        .enable(enable),
        .a     (a),
        .random(random_theta),
        .b     (theta)
    );

    // input delayed to meet theta.
    always_ff @(posedge clock) begin
        if (enable && !reset) begin
            a_q <= a;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_SHARES; i++) begin
            gamma1_q[i] = a_q[i][3:2];
            gamma0_q[i] = a_q[i][1:0];
        end
    end

    // theta*gamma0 becomes the upper half.
    masked_hpc3_mul #(
        .NUM_SHARES(NUM_SHARES),
        .BIT_WIDTH (2)
    ) u_mul_hi (
        .clock (clock),
        .reset (reset),
        .enable(enable),
        .a     (theta),
        .b     (gamma0_q),
        .r     (random_r_hi),
        .p     (random_p_hi),
        .c     (half_hi)
    );

    masked_hpc3_mul #(
        .NUM_SHARES(NUM_SHARES),
        .BIT_WIDTH (2)
    ) u_mul_lo (
        .clock (clock),
        .reset (reset),
        .enable(enable),
        .a     (theta),
        .b     (gamma1_q),
        .r     (random_r_lo),
        .p     (random_p_lo),
        .c     (half_lo)
    );

    always_comb begin
        for (int i = 0; i < NUM_SHARES; i++) begin
            b[i] = {half_hi[i], half_lo[i]};
        end
    end

endmodule

/* src/masked_bv4_inv_top.sv */
`timescale 1ns/10ps
`include "masked_bv4_inv_config.svh"

module masked_bv4_inv_top (
    input  bit                       clock,
    input  bit                       reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  aes128_package::inv_req_t in_req,
    output logic                     out_valid,
    input  logic                     out_ready,
    output aes128_package::inv_rsp_t out_rsp
);

    logic [`INV_LATENCY-1:0]    valid_q;
    logic                       advance;
    logic [`RND_THETA_BITS-1:0] random_theta;
    logic [`RND_INV_BITS-1:0]   random_inv;
    logic [`RND_INV_BITS-1:0]   random_inv_q;

    // whole pipeline moves when the output slot frees up.
    assign advance = ~valid_q[`INV_LATENCY-1] | out_ready;
    assign in_ready = advance;
    assign out_valid = valid_q[`INV_LATENCY-1];

    assign {random_inv, random_theta} = in_req.random;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q <= {valid_q[`INV_LATENCY-2:0], in_valid};
        end
    end

    // output-stage bits follow their item into stage two.
    always_ff @(posedge clock) begin
        if (advance) begin
            random_inv_q <= random_inv;
        end
    end

    masked_bv4_inv #(
        .NUM_SHARES(`NUM_SHARES)
    ) u_masked_bv4_inv (
        .clock       (clock),
        .reset       (reset),
        .enable      (advance),
        .a           (in_req.data),
        .random_theta(random_theta),
        .random_inv  (random_inv_q),
        .b           (out_rsp.data)
    );

endmodule

/* tb/tb_masked_bv4_inv.sv */
`timescale 1ns/10ps
`include "masked_bv4_inv_config.svh"

module tb_masked_bv4_inv;

    localparam int SWEEP_ITEMS = 16;
    localparam int MASK_REPS = 4;
    localparam int STREAM_ITEMS = 32;
    localparam int BP_ITEMS = 64;
    localparam int TOTAL_ITEMS = SWEEP_ITEMS + 16 * MASK_REPS + STREAM_ITEMS + BP_ITEMS + 2 * 15;
    localparam int MAX_CYCLES = 4 * TOTAL_ITEMS + 200;

    logic                     clock;
    logic                     reset;
    logic                     in_valid;
    logic                     in_ready;
    aes128_package::inv_req_t in_req;
    logic                     out_valid;
    logic                     out_ready;
    aes128_package::inv_rsp_t out_rsp;

    integer seed;
    int     cycle;
    logic   bp_mode;
    logic   gap_check;
    logic   have_prev;
    int     prev_accept;
    logic   stall_seen;

    aes128_package::bv4_shares_t held_rsp;
    aes128_package::bv4_t        exp_q[$];
    aes128_package::bv4_t        got_q[$];
    int                          accept_q[$];

    masked_bv4_inv_top u_masked_bv4_inv_top (
        .clock    (clock),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_req   (in_req),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_rsp  (out_rsp)
    );

    always #10 clock = ~clock;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (exp !== got) begin
            fail_run($sformatf("Mismatch %s exp=%0h got=%0h", name, exp, got));
        end
    endtask

    function automatic aes128_package::bv4_t recombine(input aes128_package::bv4_shares_t s);
        aes128_package::bv4_t x;
        x = '0;
        for (int i = 0; i < `NUM_SHARES; i++) begin
            x = x ^ s[i];
        end
        return x;
    endfunction

    // unmasked tower-field inverse.
    function automatic aes128_package::bv4_t ref_inverse(input aes128_package::bv4_t x);
        aes128_package::bv2_t g1;
        aes128_package::bv2_t g0;
        aes128_package::bv2_t theta;
        g1 = x[3:2];
        g0 = x[1:0];
        theta = aes128_package::bv2_sq(aes128_package::bv2_mul(g1, g0)
            ^ aes128_package::bv2_scl_sigma(aes128_package::bv2_sq(g1 ^ g0)));
        return {aes128_package::bv2_mul(theta, g0), aes128_package::bv2_mul(theta, g1)};
    endfunction

    // scoreboard, latency and hold checks.
    always @(posedge clock) begin : monitor
        int lat;
        cycle = cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            fail_run($sformatf("timeout: tests did not finish within %0d cycles", MAX_CYCLES));
        end
        if (!reset) begin
            if (stall_seen) begin
                check_value("out_valid (held)", 32'd1, 32'(out_valid));
                check_value("out_rsp (held)", 32'(held_rsp), 32'(out_rsp.data));
            end
            stall_seen = out_valid && !out_ready;
            held_rsp = out_rsp.data;
            if (in_valid && in_ready) begin
                exp_q.push_back(ref_inverse(recombine(in_req.data)));
                accept_q.push_back(cycle);
                if (gap_check && have_prev) begin
                    check_value("accept gap", 32'd1, cycle - prev_accept);
                end
                prev_accept = cycle;
                have_prev = 1'b1;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    fail_run("output transfer with no request outstanding");
                end else begin
                    check_value("out_rsp", 32'(exp_q.pop_front()), 32'(recombine(out_rsp.data)));
                    lat = cycle - accept_q.pop_front();
                    if (gap_check) begin
                        check_value("latency", `INV_LATENCY, lat);
                    end
                    got_q.push_back(recombine(out_rsp.data));
                end
            end
        end
    end

    task automatic drive_ready;
        logic [31:0] rnd;
        if (bp_mode) begin
            rnd = $random(seed);
            out_ready = rnd[0];
        end else begin
            out_ready = 1'b1;
        end
    endtask

    // fresh masks and randomness for every item.
    task automatic apply_item(input aes128_package::bv4_t x);
        logic [31:0] rnd;
        aes128_package::bv4_t last;
        last = x;
        for (int i = 0; i < `NUM_SHARES - 1; i++) begin
            rnd = $random(seed);
            in_req.data[i] = rnd[3:0];
            last = last ^ rnd[3:0];
        end
        in_req.data[`NUM_SHARES-1] = last;
        for (int k = 0; k < `RND_BITS; k++) begin
            rnd = $random(seed);
            in_req.random[k] = rnd[0];
        end
        in_valid = 1'b1;
    endtask

    task automatic send_item(input aes128_package::bv4_t x);
        logic accepted;
        @(negedge clock);
        apply_item(x);
        drive_ready();
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clock);
            accepted = in_ready;
            if (!accepted) begin
                @(negedge clock);
                drive_ready();
            end
        end
    endtask

    task automatic drain_pipeline;
        @(negedge clock);
        in_valid = 1'b0;
        drive_ready();
        while (exp_q.size() != 0) begin
            @(negedge clock);
            drive_ready();
        end
        out_ready = 1'b1;
    endtask

    task automatic after_reset_idle;
        check_value("out_valid", 32'd0, 32'(out_valid));
        check_value("in_ready", 32'd1, 32'(in_ready));
    endtask

    task automatic sweep_all_values;
        got_q.delete();
        for (int v = 0; v < SWEEP_ITEMS; v++) begin
            send_item(4'(v));
        end
        drain_pipeline();
        check_value("sweep count", SWEEP_ITEMS, got_q.size());
        check_value("out_rsp for input 0", 32'd0, 32'(got_q[0]));
    endtask

    task automatic mask_independence;
        got_q.delete();
        for (int v = 0; v < 16; v++) begin
            for (int k = 0; k < MASK_REPS; k++) begin
                send_item(4'(v));
            end
        end
        drain_pipeline();
        check_value("mask count", 16 * MASK_REPS, got_q.size());
        for (int v = 0; v < 16; v++) begin
            for (int k = 0; k < MASK_REPS; k++) begin
                check_value("out_rsp across masks", 32'(ref_inverse(4'(v))),
                            32'(got_q[v * MASK_REPS + k]));
            end
        end
    endtask

    task automatic back_to_back_stream;
        logic [31:0] rnd;
        have_prev = 1'b0;
        gap_check = 1'b1;
        for (int n = 0; n < STREAM_ITEMS; n++) begin
            rnd = $random(seed);
            send_item(rnd[3:0]);
        end
        drain_pipeline();
        gap_check = 1'b0;
    endtask

    task automatic random_back_pressure;
        logic [31:0] rnd;
        got_q.delete();
        bp_mode = 1'b1;
        for (int n = 0; n < BP_ITEMS; n++) begin
            rnd = $random(seed);
            send_item(rnd[3:0]);
        end
        drain_pipeline();
        bp_mode = 1'b0;
        check_value("back-pressure count", BP_ITEMS, got_q.size());
    endtask

    // feed each result back in.
    task automatic double_inversion;
        aes128_package::bv4_t y;
        for (int x = 1; x < 16; x++) begin
            got_q.delete();
            send_item(4'(x));
            drain_pipeline();
            y = got_q[0];
            send_item(y);
            drain_pipeline();
            check_value("double inverse", 32'(x), 32'(got_q[1]));
        end
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_req = '0;
        out_ready = 1'b0;
        seed = 32'he3ff_4eab;
        cycle = 0;
        bp_mode = 1'b0;
        gap_check = 1'b0;
        have_prev = 1'b0;
        prev_accept = 0;
        stall_seen = 1'b0;
        held_rsp = '0;
        repeat (5) @(negedge clock);
        reset = 1'b0;
        after_reset_idle();
        sweep_all_values();
        mask_independence();
        back_to_back_stream();
        random_back_pressure();
        double_inversion();
        $display("Test passed");
        $finish;
    end

endmodule

/* masked_bv4_inv.f */
+incdir+include
src/aes128_package.sv
src/masked_hpc3_mul.sv
src/masked_bv4_comp_theta.sv
src/masked_bv4_inv.sv
src/masked_bv4_inv_top.sv
tb/tb_masked_bv4_inv.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_masked_bv4_inv
FILELIST = masked_bv4_inv.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
